// File: hw/csr_decode.sv
`default_nettype none

`include "csr_settings.svh"

module csr_decode
(
    input  logic               inst_valid,
    input  csr_pkg::csr_inst_u inst,
    input  logic [31:0]        rj_value,
    input  logic [31:0]        rd_value,
    input  csr_pkg::excp_req_t excp,
    output csr_pkg::csr_req_t  req
);

    logic is_csr;
    logic is_csrrd;
    logic is_csrwr;

    // ========================================
    // Instruction class
    // ========================================
    assign is_csr   = inst_valid && (inst.raw.opcode == `OP_CSR);
    assign is_csrrd = (inst.csr.rj == 5'd0);
    assign is_csrwr = (inst.csr.rj == 5'd1);

    // ========================================
    // Request build
    // ========================================
    always_comb
    begin
        req.rd_en = is_csr;                  // All three forms return the old value.
        req.wen   = is_csr && !is_csrrd;
        req.addr  = inst.csr.csr_num;
        req.rd    = inst.csr.rd;
        req.wdata = rd_value;

        // csrxchg takes its bit mask from rj.
        if (!req.wen)
        begin
            req.wmask = 32'h0;
        end
        else if (is_csrwr)
        begin
            req.wmask = 32'hffff_ffff;
        end
        else
        begin
            req.wmask = rj_value;
        end

        req.excp = excp;                     // Passed through untouched.
    end

    // An ertn is sent as a valid request with the ertn flag set.
    always_comb
    begin
        assert (!(excp.ertn && !excp.valid))
            else $error("ertn request without excp.valid");
    end

endmodule

`default_nettype wire

// File: hw/csr_file.sv
`default_nettype none

`include "csr_settings.svh"

module csr_file
(
    input  logic              clk,
    input  logic              rst,
    input  csr_pkg::csr_req_t req,
    input  logic [13:0]       probe_addr,
    output logic [31:0]       old_data,
    output logic [31:0]       probe_data,
    output logic [31:0]       redirect_pc_next,
    output logic              redirect_valid_next,
    output logic              excp_fail_next
);

    logic [31:0] crmd;
    logic [31:0] prmd;
    logic [31:0] estat;
    logic [31:0] era;
    logic [31:0] eentry;
    logic [31:0] save [4];

    logic take_excp;
    logic take_ertn;
    logic wr_crmd;
    logic wr_prmd;
    logic wr_estat;
    logic wr_era;
    logic wr_eentry;

    // Old value with the bits selected by both masks replaced.
    function automatic logic [31:0] masked_write(input logic [31:0] old,
                                                 input logic [31:0] wmask,
                                                 input logic [31:0] wdata,
                                                 input logic [31:0] reg_mask);
        logic [31:0] m;
        m = wmask & reg_mask;
        masked_write = (old & ~m) | (wdata & m);
    endfunction

    function automatic logic [31:0] read_csr(input logic [13:0] addr);
        case (addr)
            `CSR_CRMD:   read_csr = crmd;
            `CSR_PRMD:   read_csr = prmd;
            `CSR_ESTAT:  read_csr = estat;
            `CSR_ERA:    read_csr = era;
            `CSR_EENTRY: read_csr = eentry;
            `CSR_SAVE0:  read_csr = save[0];
            `CSR_SAVE1:  read_csr = save[1];
            `CSR_SAVE2:  read_csr = save[2];
            `CSR_SAVE3:  read_csr = save[3];
            default:     read_csr = 32'h0;   // Unmapped.
        endcase
    endfunction

    // ========================================
    // Exception control
    // ========================================
    // A CSR write in the same cycle blocks the exception.
    assign excp_fail_next      = req.excp.valid && !req.excp.ertn && req.wen;
    assign take_excp           = req.excp.valid && !req.excp.ertn && !req.wen;
    assign take_ertn           = req.excp.valid && req.excp.ertn;
    assign redirect_valid_next = take_excp || take_ertn;
    assign redirect_pc_next    = req.excp.ertn ? era : eentry;

    assign wr_crmd   = req.wen && (req.addr == `CSR_CRMD);
    assign wr_prmd   = req.wen && (req.addr == `CSR_PRMD);
    assign wr_estat  = req.wen && (req.addr == `CSR_ESTAT);
    assign wr_era    = req.wen && (req.addr == `CSR_ERA);
    assign wr_eentry = req.wen && (req.addr == `CSR_EENTRY);

    // ========================================
    // Register storage
    // ========================================
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            crmd           <= 32'h0;
            crmd[`CRMD_DA] <= 1'b1;          // Direct address mode out of reset.
            prmd           <= 32'h0;
            estat          <= 32'h0;
            era            <= 32'h0;
            eentry         <= 32'h0;
            for (int i = 0; i < 4; i++)
            begin
                save[i] <= 32'h0;
            end
        end
        else
        begin
            if (wr_crmd)
            begin
                crmd <= masked_write(crmd, req.wmask, req.wdata, `CRMD_WMASK);
            end
            else if (take_excp)
            begin
                crmd[`CRMD_PLV] <= 2'b00;
                crmd[`CRMD_IE]  <= 1'b0;
            end
            else if (take_ertn)
            begin
                crmd[`CRMD_PLV] <= prmd[`PRMD_PPLV];
                crmd[`CRMD_IE]  <= prmd[`PRMD_PIE];
            end

            if (wr_prmd)
            begin
                prmd <= masked_write(prmd, req.wmask, req.wdata, `PRMD_WMASK);
            end
            else if (take_excp)
            begin
                prmd[`PRMD_PPLV] <= crmd[`CRMD_PLV];
                prmd[`PRMD_PIE]  <= crmd[`CRMD_IE];
            end

            if (wr_estat)
            begin
                estat <= masked_write(estat, req.wmask, req.wdata, `ESTAT_WMASK);
            end
            else if (take_excp)
            begin
                estat[`ESTAT_ECODE]    <= req.excp.ecode;
                estat[`ESTAT_ESUBCODE] <= req.excp.subcode;
            end

            if (wr_era)
            begin
                era <= masked_write(era, req.wmask, req.wdata, `FULL_WMASK);
            end
            else if (take_excp)
            begin
                era <= req.excp.pc;
            end

            if (wr_eentry)
            begin
                eentry <= masked_write(eentry, req.wmask, req.wdata, `EENTRY_WMASK);
            end

            for (int i = 0; i < 4; i++)
            begin
                if (req.wen && (req.addr == `CSR_SAVE0 + 14'(i)))
                begin
                    save[i] <= masked_write(save[i], req.wmask, req.wdata, `FULL_WMASK);
                end
            end
        end
    end

    // ========================================
    // Read ports
    // ========================================
    always_comb
    begin
        old_data = read_csr(req.addr);       // Value before this cycle's write.
    end

    always_comb
    begin
        probe_data = read_csr(probe_addr);
    end

    // Hardware side effects must never reach reserved bits either.
    reserved_bits_zero: assert property (@(posedge clk) disable iff (rst)
        ((crmd & ~`CRMD_WMASK) == 32'h0) &&
        ((prmd & ~`PRMD_WMASK) == 32'h0) &&
        ((eentry & ~`EENTRY_WMASK) == 32'h0))
        else $error("reserved CSR bits set");

    // A blocked exception leaves ERA alone unless software wrote it.
    blocked_excp_keeps_era: assert property (@(posedge clk) disable iff (rst)
        (excp_fail_next && !wr_era) |=> (era == $past(era)))
        else $error("blocked exception changed ERA");

endmodule

`default_nettype wire

// File: hw/csr_pkg.sv
`default_nettype none

package csr_pkg;

    // Raw view, only the major opcode is looked at.
    typedef struct packed {
        logic [7:0]  opcode;
        logic [23:0] payload;
    } csr_raw_t;

    typedef struct packed {
        logic [7:0]  opcode;
        logic [13:0] csr_num;
        logic [4:0]  rj;       // 0 csrrd, 1 csrwr, else csrxchg.
        logic [4:0]  rd;
    } csr_fields_t;

    typedef union packed {
        csr_raw_t    raw;
        csr_fields_t csr;
    } csr_inst_u;

    // Exception or ertn request from the pipeline.
    typedef struct packed {
        logic        valid;
        logic        ertn;
        logic [5:0]  ecode;
        logic [8:0]  subcode;
        logic [31:0] pc;       // Faulting pc.
    } excp_req_t;

    typedef struct packed {
        logic        rd_en;
        logic        wen;
        logic [13:0] addr;
        logic [31:0] wmask;
        logic [31:0] wdata;
        logic [4:0]  rd;
        excp_req_t   excp;
    } csr_req_t;

    // Registered outcome, one cycle after the request.
    typedef struct packed {
        logic        rd_valid;
        logic [4:0]  rd;
        logic [31:0] rd_data;
        logic        redirect_valid;
        logic [31:0] redirect_pc;
        logic        excp_fail;
    } csr_result_t;

endpackage

`default_nettype wire

// File: hw/csr_redirect.sv
`default_nettype none

module csr_redirect
(
    input  logic                 clk,
    input  logic                 rst,
    input  csr_pkg::csr_req_t    req,
    input  logic [31:0]          old_data,
    input  logic [31:0]          redirect_pc_next,
    input  logic                 redirect_valid_next,
    input  logic                 excp_fail_next,
    output csr_pkg::csr_result_t res
);

    // ========================================
    // Result stage
    // ========================================
    always_ff @(posedge clk)
    begin
        // Payload follows the inputs every cycle.
        res.rd          <= req.rd;
        res.rd_data     <= old_data;
        res.redirect_pc <= redirect_pc_next;

        if (rst)
        begin
            res.rd_valid       <= 1'b0;
            res.redirect_valid <= 1'b0;
            res.excp_fail      <= 1'b0;
        end
        else
        begin
            res.rd_valid       <= req.rd_en;
            res.redirect_valid <= redirect_valid_next;
            res.excp_fail      <= excp_fail_next;
        end
    end

    // A blocked exception must not also redirect the fetch.
    no_redirect_on_fail: assert property (@(posedge clk) disable iff (rst)
        !(res.redirect_valid && res.excp_fail))
        else $error("redirect and excp_fail raised together");

endmodule

`default_nettype wire

// File: hw/csr_unit.sv
`default_nettype none

module csr_unit
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 inst_valid,
    input  csr_pkg::csr_inst_u   inst,
    input  logic [31:0]          rj_value,
    input  logic [31:0]          rd_value,
    input  csr_pkg::excp_req_t   excp,
    input  logic [13:0]          probe_addr,
    output csr_pkg::csr_result_t res,
    output logic [31:0]          probe_data
);

    import csr_pkg::*;

    csr_req_t    req;
    logic [31:0] old_data;
    logic [31:0] redirect_pc_next;
    logic        redirect_valid_next;
    logic        excp_fail_next;

    csr_decode u_decode
    (
        .inst_valid (inst_valid),
        .inst       (inst),
        .rj_value   (rj_value),
        .rd_value   (rd_value),
        .excp       (excp),
        .req        (req)
    );

    csr_file u_file
    (
        .clk                 (clk),
        .rst                 (rst),
        .req                 (req),
        .probe_addr          (probe_addr),
        .old_data            (old_data),
        .probe_data          (probe_data),
        .redirect_pc_next    (redirect_pc_next),
        .redirect_valid_next (redirect_valid_next),
        .excp_fail_next      (excp_fail_next)
    );

    csr_redirect u_redirect
    (
        .clk                 (clk),
        .rst                 (rst),
        .req                 (req),
        .old_data            (old_data),
        .redirect_pc_next    (redirect_pc_next),
        .redirect_valid_next (redirect_valid_next),
        .excp_fail_next      (excp_fail_next),
        .res                 (res)
    );

endmodule

`default_nettype wire

// File: include/csr_settings.svh
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// ========================================
// CSR addresses
// ========================================
`define CSR_CRMD        14'h000
`define CSR_PRMD        14'h001
`define CSR_ESTAT       14'h005
`define CSR_ERA         14'h006
`define CSR_EENTRY      14'h00c
`define CSR_SAVE0       14'h030
`define CSR_SAVE1       14'h031
`define CSR_SAVE2       14'h032
`define CSR_SAVE3       14'h033

// Major opcode shared by csrrd, csrwr and csrxchg.
`define OP_CSR          8'b00000100

// ========================================
// Software writable bits
// ========================================
`define CRMD_WMASK      32'h0000_01ff  // PLV, IE, DA, PG, DATF, DATM.
`define PRMD_WMASK      32'h0000_0007  // PPLV, PIE.
`define ESTAT_WMASK     32'h0000_0003  // Soft interrupt bits.
`define EENTRY_WMASK    32'hffff_ffc0  // Entry VA, 64 byte aligned.
`define FULL_WMASK      32'hffff_ffff  // ERA and SAVE0-3.

// ========================================
// Field positions
// ========================================
`define CRMD_PLV        1:0
`define CRMD_IE         2
`define CRMD_DA         3
`define PRMD_PPLV       1:0
`define PRMD_PIE        2
`define ESTAT_ECODE     21:16
`define ESTAT_ESUBCODE  30:22

`endif

// File: run_sim.sh
#!/bin/sh
# Builds the CSR unit testbench with Verilator and runs it.

log=sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_csr_unit \
    -Mdir obj_dir -o sim_csr_unit
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_csr_unit > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation passed$" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1

// File: sources.f
+incdir+include
hw/csr_pkg.sv
hw/csr_decode.sv
hw/csr_file.sv
hw/csr_redirect.sv
hw/csr_unit.sv
test/csr_checker.sv
test/tb_csr_unit.sv

// File: test/csr_checker.sv
`default_nettype none

`include "csr_settings.svh"

module csr_checker
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 inst_valid,
    input  csr_pkg::csr_inst_u   inst,
    input  logic [31:0]          rj_value,
    input  logic [31:0]          rd_value,
    input  csr_pkg::excp_req_t   excp,
    input  logic [13:0]          probe_addr,
    input  csr_pkg::csr_result_t res,
    input  logic [31:0]          probe_data,
    output int                   check_count,
    output int                   error_count
);

    import csr_pkg::*;

    logic [31:0] regs [9];    // CRMD, PRMD, ESTAT, ERA, EENTRY, SAVE0-3.
    csr_result_t exp_res;

    function automatic int reg_index(input logic [13:0] addr);
        case (addr)
            `CSR_CRMD:   return 0;
            `CSR_PRMD:   return 1;
            `CSR_ESTAT:  return 2;
            `CSR_ERA:    return 3;
            `CSR_EENTRY: return 4;
            `CSR_SAVE0:  return 5;
            `CSR_SAVE1:  return 6;
            `CSR_SAVE2:  return 7;
            `CSR_SAVE3:  return 8;
            default:     return -1;
        endcase
    endfunction

    function automatic logic [31:0] writable(input int idx);
        case (idx)
            0:       return `CRMD_WMASK;
            1:       return `PRMD_WMASK;
            2:       return `ESTAT_WMASK;
            4:       return `EENTRY_WMASK;
            default: return `FULL_WMASK;
        endcase
    endfunction

    function automatic logic [31:0] model_read(input logic [13:0] addr);
        int idx;
        idx = reg_index(addr);
        return (idx < 0) ? 32'h0 : regs[idx];
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_result();
        compare("res.rd_valid", 32'(res.rd_valid), 32'(exp_res.rd_valid));
        if (exp_res.rd_valid)
        begin
            compare("res.rd", 32'(res.rd), 32'(exp_res.rd));
            compare("res.rd_data", res.rd_data, exp_res.rd_data);
        end
        compare("res.redirect_valid", 32'(res.redirect_valid), 32'(exp_res.redirect_valid));
        if (exp_res.redirect_valid)
        begin
            compare("res.redirect_pc", res.redirect_pc, exp_res.redirect_pc);
        end
        compare("res.excp_fail", 32'(res.excp_fail), 32'(exp_res.excp_fail));
    endtask

    // ========================================
    // Model step for the request now on the inputs
    // ========================================
    task automatic step_model();
        logic        is_csr;
        logic        wen;
        logic        is_exc;
        logic        take_exc;
        logic        take_ertn;
        logic [31:0] m;
        logic [31:0] crmd_old;
        logic [31:0] prmd_old;
        int          idx;
        is_csr    = inst_valid && (inst.raw.opcode == `OP_CSR);
        wen       = is_csr && (inst.csr.rj != 5'd0);
        is_exc    = excp.valid && !excp.ertn;
        take_exc  = is_exc && !wen;
        take_ertn = excp.valid && excp.ertn;
        crmd_old  = regs[0];
        prmd_old  = regs[1];

        exp_res.rd_valid       = is_csr;
        exp_res.rd             = inst.csr.rd;
        exp_res.rd_data        = model_read(inst.csr.csr_num);
        exp_res.redirect_valid = take_exc || take_ertn;
        exp_res.redirect_pc    = take_ertn ? regs[3] : regs[4];  // Values before the edge.
        exp_res.excp_fail      = is_exc && wen;

        idx = reg_index(inst.csr.csr_num);
        if (wen && idx >= 0)
        begin
            m         = ((inst.csr.rj == 5'd1) ? 32'hffff_ffff : rj_value) & writable(idx);
            regs[idx] = regs[idx] ^ ((regs[idx] ^ rd_value) & m);
        end
        if (take_exc)
        begin
            regs[1][`PRMD_PPLV]      = crmd_old[`CRMD_PLV];
            regs[1][`PRMD_PIE]       = crmd_old[`CRMD_IE];
            regs[0][`CRMD_PLV]       = 2'b00;
            regs[0][`CRMD_IE]        = 1'b0;
            regs[2][`ESTAT_ECODE]    = excp.ecode;
            regs[2][`ESTAT_ESUBCODE] = excp.subcode;
            regs[3]                  = excp.pc;
        end
        if (take_ertn)
        begin
            regs[0][`CRMD_PLV] = prmd_old[`PRMD_PPLV];
            regs[0][`CRMD_IE]  = prmd_old[`PRMD_PIE];
        end
    endtask

    initial
    begin
        check_count = 0;
        error_count = 0;
    end

    // Inputs and res are both settled at the falling edge.
    always @(negedge clk)
    begin
        if (rst)
        begin
            regs              = '{default: 32'h0};
            regs[0][`CRMD_DA] = 1'b1;
            exp_res           = '0;    // Flags clear after reset.
        end
        else
        begin
            check_result();
            compare("probe_data", probe_data, model_read(probe_addr));
            step_model();
        end
    end

endmodule

`default_nettype wire

// File: test/tb_csr_unit.sv
`default_nettype none

`include "csr_settings.svh"

module tb_csr_unit;

    import csr_pkg::*;

    localparam int clk_half        = 20;
    localparam int rand_cycles     = 3000;
    localparam int result_timeout  = 8;
    localparam int watchdog_cycles = 20000;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        inst_valid;
    csr_inst_u   inst;
    logic [31:0] rj_value;
    logic [31:0] rd_value;
    excp_req_t   excp;
    logic [13:0] probe_addr;
    csr_result_t res;
    logic [31:0] probe_data;
    int          check_count;
    int          error_count;
    int          tb_errors = 0;
    int          test_start;
    integer      seed = 32'hcab98d44;

    // Nine mapped CSRs first, then unmapped ones.
    logic [13:0] addr_pool [14] = '{`CSR_CRMD, `CSR_PRMD, `CSR_ESTAT, `CSR_ERA, `CSR_EENTRY,
        `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3, 14'h002, 14'h007, 14'h034, 14'h100,
        14'h3fff};

    csr_unit DUT (.*);

    csr_checker u_checker (.*);

    initial
    begin
        forever
        begin
            #(clk_half) clk = ~clk;
        end
    end

    function automatic logic [31:0] rand_word();
        rand_word = $random(seed);
    endfunction

    function automatic logic [13:0] rand_addr();
        logic [31:0] r;
        r = rand_word();
        return addr_pool[int'(r % 32'd14)];
    endfunction

    function automatic int total_errors();
        return error_count + tb_errors;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #5;
        probe_addr = rand_addr();
    endtask

    task automatic drive_idle();
        inst_valid = 1'b0;
        inst       = '0;
        rj_value   = 32'h0;
        rd_value   = 32'h0;
        excp       = '0;
    endtask

    task automatic advance_idle();
        next_cycle();
        drive_idle();
    endtask

    // Kind 0 csrrd, 1 csrwr, 2 csrxchg.
    task automatic drive_csr(input logic [1:0] kind, input logic [13:0] addr, input logic [4:0] rd,
                             input logic [31:0] mask, input logic [31:0] data);
        logic [31:0] r;
        r                 = rand_word();
        inst_valid        = 1'b1;
        inst.csr.opcode   = `OP_CSR;
        inst.csr.csr_num  = addr;
        inst.csr.rd       = rd;
        inst.csr.rj       = (kind == 2'd0) ? 5'd0 : (kind == 2'd1) ? 5'd1 :
                            (r[4:0] < 5'd2) ? 5'd7 : r[4:0];
        rj_value          = mask;
        rd_value          = data;
    endtask

    task automatic drive_excp(input logic ertn, input logic [5:0] ecode,
                              input logic [8:0] subcode, input logic [31:0] pc);
        excp.valid   = 1'b1;
        excp.ertn    = ertn;
        excp.ecode   = ecode;
        excp.subcode = subcode;
        excp.pc      = pc;
    endtask

    // Looks at res just after each rising edge, where it is stable.
    task automatic wait_result(input string what, input logic want_fail);
        logic found;
        int   i;
        found = want_fail ? res.excp_fail : res.redirect_valid;
        i     = 0;
        while (!found && i < result_timeout)
        begin
            next_cycle();
            found = want_fail ? res.excp_fail : res.redirect_valid;
            i++;
        end
        if (!found)
        begin
            tb_errors++;
            $display("no %s seen within %0d cycles of the request", what, result_timeout);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s done, %0d errors", name, total_errors() - test_start);
        test_start = total_errors();
    endtask

    task automatic drive_random();
        logic [31:0] r;
        r = rand_word();
        drive_idle();
        if (r[1:0] == 2'd3)
        begin
            inst       = rand_word();
            inst_valid = r[8];
            if (inst.raw.opcode == `OP_CSR)
                inst.raw.opcode = 8'h05;
        end
        else
        begin
            drive_csr(r[1:0], rand_addr(), r[13:9], rand_word(), rand_word());
            inst_valid = (r[16:14] != 3'd0);
        end
        if (r[7:5] == 3'd0)
        begin
            drive_excp(1'b0, r[22:17], r[31:23], rand_word());  // Sometimes beside a write.
        end
        else if (r[7:4] == 4'd2)
        begin
            inst.csr.rj = 5'd0;                                  // An ertn comes with no write.
            drive_excp(1'b1, 6'h0, 9'h0, 32'h0);
        end
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial
    begin
        drive_idle();
        probe_addr = `CSR_CRMD;
        for (int i = 0; i < 5; i++)
        begin
            @(posedge clk);
        end
        #5 rst = 1'b0;
        test_start = 0;

        for (int i = 0; i < 9; i++)
        begin
            next_cycle();
            probe_addr = addr_pool[i];
        end
        end_test("reset");

        drive_csr(2'd1, `CSR_SAVE0, 5'd3, 32'h0, 32'hdead_beef);
        advance_idle();
        drive_csr(2'd0, `CSR_SAVE0, 5'd4, 32'h0, 32'h0);
        advance_idle();
        drive_csr(2'd2, `CSR_CRMD, 5'd5, 32'h0000_00f7, 32'hffff_ffff);
        advance_idle();
        drive_csr(2'd1, `CSR_EENTRY, 5'd6, 32'h0, 32'h1c00_8abc);
        advance_idle();
        drive_csr(2'd1, `CSR_SAVE2, 5'd7, 32'h0, 32'h0bad_cafe);
        next_cycle();
        drive_csr(2'd0, `CSR_SAVE2, 5'd8, 32'h0, 32'h0);      // Back to back with the write.
        advance_idle();
        inst_valid = 1'b1;
        inst       = 32'h0280_0421;
        advance_idle();
        drive_csr(2'd1, `CSR_SAVE3, 5'd9, 32'h0, 32'h1111_2222);
        inst_valid = 1'b0;
        advance_idle();
        end_test("csr_ops");

        for (int i = 9; i < 14; i++)
        begin
            drive_csr(2'd1, addr_pool[i], 5'd10, 32'h0, rand_word());
            next_cycle();
            drive_csr(2'd0, addr_pool[i], 5'd11, 32'h0, 32'h0);
            advance_idle();
        end
        end_test("unmapped");

        drive_excp(1'b0, 6'h0d, 9'h003, 32'h1c00_1234);
        advance_idle();
        wait_result("redirect", 1'b0);
        for (int i = 0; i < 4; i++)
        begin
            drive_csr(2'd0, addr_pool[i], 5'd12, 32'h0, 32'h0);
            advance_idle();
        end
        end_test("exception");

        drive_excp(1'b1, 6'h0, 9'h0, 32'h0);
        advance_idle();
        wait_result("redirect", 1'b0);
        end_test("ertn");

        drive_csr(2'd1, `CSR_SAVE1, 5'd13, 32'h0, 32'h1234_5678);
        drive_excp(1'b0, 6'h08, 9'h000, 32'h1c00_2000);
        advance_idle();
        wait_result("excp_fail", 1'b1);
        drive_csr(2'd2, `CSR_CRMD, 5'd14, 32'h0000_0007, 32'h0000_0007);
        drive_excp(1'b0, 6'h0a, 9'h001, 32'h1c00_3000);
        advance_idle();
        wait_result("excp_fail", 1'b1);
        end_test("conflict");

        next_cycle();
        for (int i = 0; i < rand_cycles; i++)
        begin
            drive_random();
            next_cycle();
        end
        drive_idle();
        end_test("random");

        next_cycle();
        next_cycle();
        $display("checks %0d, errors %0d", check_count, total_errors());
        if (total_errors() == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    initial
    begin
        for (int c = 0; c < watchdog_cycles; c++)
        begin
            @(posedge clk);
        end
        $display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
